//--- cia_pkg.sv
// Shared definitions for the 8520 interface adapter
// Register address map, bus request and committed access types
// Timer control word, read views, PB drive, interrupt word and sources

package cia_pkg;

    typedef enum logic [3:0] {
        PRA, PRB, DDRA, DDRB,
        TALO, TAHI, TBLO, TBHI,
        TOD_LO, TOD_MID, TOD_HI, RSVD,
        SDR, ICR, CRA, CRB
    } reg_addr_e;

    typedef enum logic {
        TIMER_A,
        TIMER_B
    } timer_sel_e;

    // Inputs of one WISHBONE cycle
    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        reg_addr_e  adr;
        logic [7:0] dat;
    } wb_req_t;

    // Access as it commits, valid in the ACK cycle
    typedef struct packed {
        logic       wr;
        logic       rd;
        reg_addr_e  addr;
        logic [7:0] wdata;
    } bus_acc_t;

    typedef struct packed {
        logic phi_tick;
        logic cnt_rise;
        logic cnt_high;
        logic ta_underflow;
    } count_src_t;

    // CRA/CRB layout, bit 0 is start
    typedef struct packed {
        logic       alarm_sel;
        logic [1:0] inmode;
        logic       force_load;
        logic       oneshot;
        logic       outmode_toggle;
        logic       pbon;
        logic       start;
    } timer_cr_t;

    typedef struct packed {
        logic [15:0] count;
        timer_cr_t   cr;
    } timer_view_t;

    typedef struct packed {
        logic en;
        logic val;
    } pb_drive_t;

    typedef struct packed {
        logic [7:0] hi;
        logic [7:0] mid;
        logic [7:0] lo;
    } tod_view_t;

    typedef struct packed {
        logic       set_clear;
        logic       rsvd;
        logic [5:0] mask;
    } icr_wr_t;

    typedef struct packed {
        logic       irq;
        logic [1:0] zero;
        logic [4:0] flags;
    } icr_rd_t;

    // Same ICR byte, decoded differently for writes and reads
    typedef union packed {
        icr_wr_t wr;
        icr_rd_t rd;
    } icr_word_u;

    // Bit order matches the ICR flag bits
    typedef struct packed {
        logic flag;
        logic serial;
        logic alarm;
        logic tb_uf;
        logic ta_uf;
    } irq_src_t;

endpackage

//--- cia_ctrl_regs.sv
`timescale 1ns/1ps
// WISHBONE slave handshake and committed access decode
// Registered read data mux over all register blocks
// Port A/B data and direction registers with PB6/PB7 timer override
// CNT input edge detection for the timer count sources

module cia_ctrl_regs (
    input  logic                 CLK_I,
    input  logic                 reset_n,
    input  cia_pkg::wb_req_t     wb_i,
    output logic                 ack_o,
    output logic [7:0]           dat_o,
    input  logic [7:0]           pa_i,
    input  logic [7:0]           pb_i,
    output logic [7:0]           pa_o,
    output logic [7:0]           pb_o,
    input  logic                 phi_tick_i,
    input  logic                 cnt_i,
    input  cia_pkg::timer_view_t ta_view_i,
    input  cia_pkg::timer_view_t tb_view_i,
    input  cia_pkg::tod_view_t   tod_view_i,
    input  cia_pkg::icr_word_u   icr_view_i,
    input  cia_pkg::pb_drive_t   ta_pb_i,
    input  cia_pkg::pb_drive_t   tb_pb_i,
    input  logic                 ta_underflow_i,
    output cia_pkg::bus_acc_t    acc_o,
    output cia_pkg::count_src_t  count_src_o
);
    import cia_pkg::*;

    logic [7:0] pra_q;
    logic [7:0] prb_q;
    logic [7:0] ddra_q;
    logic [7:0] ddrb_q;
    logic       cnt_last_q;
    logic       wb_start;
    logic [7:0] pa_mix;
    logic [7:0] pb_mix;
    logic [7:0] prb_wr_mask;
    logic [7:0] rd_data;

    // New request seen while not acknowledging
    assign wb_start = wb_i.cyc && wb_i.stb && !ack_o;

    assign acc_o.wr    = ack_o && wb_i.cyc && wb_i.stb && wb_i.we;
    assign acc_o.rd    = ack_o && wb_i.cyc && wb_i.stb && !wb_i.we;
    assign acc_o.addr  = wb_i.adr;
    assign acc_o.wdata = wb_i.dat;

    assign count_src_o.phi_tick     = phi_tick_i;
    assign count_src_o.cnt_rise     = cnt_i && !cnt_last_q;
    assign count_src_o.cnt_high     = cnt_i;
    assign count_src_o.ta_underflow = ta_underflow_i;

    // Direction 1 drives the register bit, 0 passes the pin
    assign pa_mix = (ddra_q & pra_q) | (~ddra_q & pa_i);

    always_comb begin
        pb_mix = (ddrb_q & prb_q) | (~ddrb_q & pb_i);
        if (ta_pb_i.en) begin
            pb_mix[6] = ta_pb_i.val;
        end
        if (tb_pb_i.en) begin
            pb_mix[7] = tb_pb_i.val;
        end
    end

    assign pa_o = pa_mix;
    assign pb_o = pb_mix;

    // Timer-driven PB bits are kept out of port writes
    assign prb_wr_mask = {~tb_pb_i.en, ~ta_pb_i.en, 6'h3f};

    always_comb begin
        case (wb_i.adr)
            PRA:     rd_data = pa_mix;
            PRB:     rd_data = pb_mix;
            DDRA:    rd_data = ddra_q;
            DDRB:    rd_data = ddrb_q;
            TALO:    rd_data = ta_view_i.count[7:0];
            TAHI:    rd_data = ta_view_i.count[15:8];
            TBLO:    rd_data = tb_view_i.count[7:0];
            TBHI:    rd_data = tb_view_i.count[15:8];
            TOD_LO:  rd_data = tod_view_i.lo;
            TOD_MID: rd_data = tod_view_i.mid;
            TOD_HI:  rd_data = tod_view_i.hi;
            ICR:     rd_data = icr_view_i;
            CRA:     rd_data = ta_view_i.cr;
            CRB:     rd_data = tb_view_i.cr;
            default: rd_data = 8'h00;
        endcase
    end

    always_ff @(posedge CLK_I or negedge reset_n) begin
        if (!reset_n) begin
            ack_o      <= 1'b0;
            cnt_last_q <= 1'b0;
            pra_q      <= 8'h00;
            prb_q      <= 8'h00;
            ddra_q     <= 8'h00;
            ddrb_q     <= 8'h00;
        end else begin
            ack_o      <= wb_start;
            cnt_last_q <= cnt_i;
            if (acc_o.wr) begin
                case (acc_o.addr)
                    PRA:     pra_q  <= acc_o.wdata;
                    PRB:     prb_q  <= (prb_q & ~prb_wr_mask) | (acc_o.wdata & prb_wr_mask);
                    DDRA:    ddra_q <= acc_o.wdata;
                    DDRB:    ddrb_q <= acc_o.wdata;
                    default: ;
                endcase
            end
        end
    end

    // Read data captured on the edge that raises ACK
    always_ff @(posedge CLK_I) begin
        if (wb_start) begin
            dat_o <= rd_data;
        end
    end

    a_ack_single: assert property (
        @(posedge CLK_I) disable iff (!reset_n) ack_o |=> !ack_o
    );

endmodule

//--- cia_interval_timer.sv
`timescale 1ns/1ps
// One 16-bit interval timer with latch and down counter
// Control register, count-source select and PB pin drive

module cia_interval_timer #(
    parameter cia_pkg::timer_sel_e TIMER_SEL = cia_pkg::TIMER_A
) (
    input  logic                 CLK_I,
    input  logic                 reset_n,
    input  cia_pkg::bus_acc_t    acc_i,
    input  cia_pkg::count_src_t  count_src_i,
    output cia_pkg::timer_view_t view_o,
    output cia_pkg::pb_drive_t   pb_o,
    output logic                 underflow_o
);
    import cia_pkg::*;

    localparam reg_addr_e ADDR_LO = reg_addr_e'((TIMER_SEL == TIMER_A) ? TALO : TBLO);
    localparam reg_addr_e ADDR_HI = reg_addr_e'((TIMER_SEL == TIMER_A) ? TAHI : TBHI);
    localparam reg_addr_e ADDR_CR = reg_addr_e'((TIMER_SEL == TIMER_A) ? CRA : CRB);

    logic [15:0] latch_q;
    logic [15:0] count_q;
    timer_cr_t   cr_q;
    timer_cr_t   cr_wr;
    logic        underflow_q;
    logic        pb_val_q;
    logic        tick_src;
    logic        tick;
    logic        lo_wr;
    logic        hi_wr;
    logic        cr_wr_en;
    logic        force_load;
    logic        hi_load;
    logic        uf_next;

    assign lo_wr      = acc_i.wr && (acc_i.addr == ADDR_LO);
    assign hi_wr      = acc_i.wr && (acc_i.addr == ADDR_HI);
    assign cr_wr_en   = acc_i.wr && (acc_i.addr == ADDR_CR);
    assign force_load = cr_wr_en && acc_i.wdata[4];
    assign hi_load    = hi_wr && !cr_q.start;

    // Timer A only has the phi and CNT modes, no alarm select
    always_comb begin
        cr_wr            = timer_cr_t'(acc_i.wdata);
        cr_wr.force_load = 1'b0;
        if (TIMER_SEL == TIMER_A) begin
            cr_wr.inmode[1] = 1'b0;
            cr_wr.alarm_sel = 1'b0;
        end
    end

    always_comb begin
        case (cr_q.inmode)
            2'b00:   tick_src = count_src_i.phi_tick;
            2'b01:   tick_src = count_src_i.cnt_rise;
            2'b10:   tick_src = count_src_i.ta_underflow;
            default: tick_src = count_src_i.ta_underflow && count_src_i.cnt_high;
        endcase
        tick = tick_src && cr_q.start;
    end

    assign uf_next = tick && (count_q == 16'd1) && !force_load;

    always_ff @(posedge CLK_I or negedge reset_n) begin
        if (!reset_n) begin
            latch_q     <= 16'hffff;
            count_q     <= 16'h0000;
            cr_q        <= '0;
            underflow_q <= 1'b0;
            pb_val_q    <= 1'b0;
        end else begin
            underflow_q <= uf_next;
            if (lo_wr) begin
                latch_q[7:0] <= acc_i.wdata;
            end
            if (hi_wr) begin
                latch_q[15:8] <= acc_i.wdata;
            end
            if (force_load || uf_next) begin
                count_q <= latch_q;
            end else if (hi_load) begin
                count_q <= {acc_i.wdata, latch_q[7:0]};
            end else if (tick) begin
                count_q <= count_q - 16'd1;
            end
            // One-shot stops itself at underflow
            if (uf_next && cr_q.oneshot) begin
                cr_q.start <= 1'b0;
            end
            if (hi_wr && cr_q.oneshot) begin
                cr_q.start <= 1'b1;
            end
            if (cr_wr_en) begin
                cr_q <= cr_wr;
            end
            pb_val_q <= cr_q.outmode_toggle ? cr_q.start : underflow_q;
        end
    end

    assign view_o.count = count_q;
    assign view_o.cr    = cr_q;
    assign pb_o.en      = cr_q.pbon;
    assign pb_o.val     = pb_val_q;
    assign underflow_o  = underflow_q;

    // A latch of 1 legitimately underflows on every tick
    a_uf_single: assert property (
        @(posedge CLK_I) disable iff (!reset_n)
        underflow_q && (latch_q != 16'd1) |=> !underflow_q
    );

endmodule

//--- cia_tod_clock.sv
`timescale 1ns/1ps
// 24-bit time-of-day counter with write-stop and restart
// Alarm register, read latch and alarm compare

module cia_tod_clock (
    input  logic               CLK_I,
    input  logic               reset_n,
    input  cia_pkg::bus_acc_t  acc_i,
    input  logic               tod_i,
    input  logic               alarm_sel_i,
    output cia_pkg::tod_view_t view_o,
    output logic               alarm_o
);
    import cia_pkg::*;

    logic [23:0] count_q;
    logic [23:0] alarm_q;
    logic [23:0] latch_q;
    logic        stopped_q;
    logic        latched_q;
    logic        tod_wr;
    logic        rd_lo;
    logic        rd_hi;

    assign tod_wr = acc_i.wr && (acc_i.addr inside {TOD_LO, TOD_MID, TOD_HI});
    assign rd_lo  = acc_i.rd && (acc_i.addr == TOD_LO);
    assign rd_hi  = acc_i.rd && (acc_i.addr == TOD_HI);

    always_ff @(posedge CLK_I or negedge reset_n) begin
        if (!reset_n) begin
            count_q   <= 24'h000000;
            alarm_q   <= 24'hffffff;
            stopped_q <= 1'b1;
            latched_q <= 1'b0;
        end else begin
            if (tod_wr && !alarm_sel_i) begin
                case (acc_i.addr)
                    TOD_LO:  count_q[7:0]   <= acc_i.wdata;
                    TOD_MID: count_q[15:8]  <= acc_i.wdata;
                    default: count_q[23:16] <= acc_i.wdata;
                endcase
                // High byte halts the clock until the low byte is written
                if (acc_i.addr == TOD_HI) begin
                    stopped_q <= 1'b1;
                end else if (acc_i.addr == TOD_LO) begin
                    stopped_q <= 1'b0;
                end
            end else if (tod_i && !stopped_q) begin
                count_q <= count_q + 24'd1;
            end
            if (tod_wr && alarm_sel_i) begin
                case (acc_i.addr)
                    TOD_LO:  alarm_q[7:0]   <= acc_i.wdata;
                    TOD_MID: alarm_q[15:8]  <= acc_i.wdata;
                    default: alarm_q[23:16] <= acc_i.wdata;
                endcase
            end
            if (rd_hi) begin
                latched_q <= 1'b1;
            end else if (rd_lo) begin
                latched_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK_I) begin
        if (rd_hi) begin
            latch_q <= count_q;
        end
    end

    assign view_o.hi  = count_q[23:16];
    assign view_o.mid = latched_q ? latch_q[15:8] : count_q[15:8];
    assign view_o.lo  = latched_q ? latch_q[7:0] : count_q[7:0];
    assign alarm_o    = (count_q == alarm_q);

endmodule

//--- cia_irq_ctrl.sv
`timescale 1ns/1ps
// Interrupt flag register and mask register
// ICR read and clear, set/clear mask writes, irq_n output

module cia_irq_ctrl (
    input  logic               CLK_I,
    input  logic               reset_n,
    input  cia_pkg::bus_acc_t  acc_i,
    input  cia_pkg::irq_src_t  src_i,
    output cia_pkg::icr_word_u view_o,
    output logic               irq_n_o
);
    import cia_pkg::*;

    logic [4:0] flags_q;
    logic [4:0] mask_q;
    logic       irq_q;
    logic       icr_rd;
    logic       icr_wr;
    icr_word_u  wr_word;

    assign icr_rd  = acc_i.rd && (acc_i.addr == ICR);
    assign icr_wr  = acc_i.wr && (acc_i.addr == ICR);
    assign wr_word = icr_word_u'(acc_i.wdata);

    always_ff @(posedge CLK_I or negedge reset_n) begin
        if (!reset_n) begin
            flags_q <= 5'b00000;
            mask_q  <= 5'b00000;
            irq_q   <= 1'b0;
        end else begin
            // Fresh events win over the read clear
            flags_q <= (icr_rd ? 5'b00000 : flags_q) | src_i;
            irq_q   <= (icr_rd ? 1'b0 : irq_q) | (|(src_i & mask_q));
            if (icr_wr) begin
                if (wr_word.wr.set_clear) begin
                    mask_q <= mask_q | wr_word.wr.mask[4:0];
                end else begin
                    mask_q <= mask_q & ~wr_word.wr.mask[4:0];
                end
            end
        end
    end

    always_comb begin
        view_o.rd.irq   = irq_q;
        view_o.rd.zero  = 2'b00;
        view_o.rd.flags = flags_q;
    end

    assign irq_n_o = ~irq_q;

    a_irq_has_flag: assert property (
        @(posedge CLK_I) disable iff (!reset_n) !irq_n_o |-> (flags_q != 5'b00000)
    );

endmodule

//--- cia_top.sv
`timescale 1ns/1ps
// Top level of the 8520 interface adapter
// Register port, two interval timers, TOD clock and interrupt controller

module cia_top (
    input  logic             CLK_I,
    input  logic             reset_n,
    input  cia_pkg::wb_req_t wb_i,
    output logic             ack_o,
    output logic [7:0]       dat_o,
    input  logic             phi_tick_i,
    input  logic [7:0]       pa_i,
    input  logic [7:0]       pb_i,
    output logic [7:0]       pa_o,
    output logic [7:0]       pb_o,
    input  logic             flag_n_i,
    input  logic             tod_i,
    input  logic             cnt_i,
    output logic             irq_n_o
);
    import cia_pkg::*;

    bus_acc_t    acc;
    count_src_t  count_src;
    timer_view_t ta_view;
    timer_view_t tb_view;
    tod_view_t   tod_view;
    icr_word_u   icr_view;
    pb_drive_t   ta_pb;
    pb_drive_t   tb_pb;
    irq_src_t    irq_src;
    logic        ta_uf;
    logic        tb_uf;
    logic        tod_alarm;

    // Serial port is not implemented, FLAG is active low
    assign irq_src = '{flag: ~flag_n_i, serial: 1'b0, alarm: tod_alarm,
                       tb_uf: tb_uf, ta_uf: ta_uf};

    cia_ctrl_regs u_ctrl_regs (
        .CLK_I(CLK_I), .reset_n(reset_n), .wb_i(wb_i), .ack_o(ack_o), .dat_o(dat_o),
        .pa_i(pa_i), .pb_i(pb_i), .pa_o(pa_o), .pb_o(pb_o),
        .phi_tick_i(phi_tick_i), .cnt_i(cnt_i),
        .ta_view_i(ta_view), .tb_view_i(tb_view), .tod_view_i(tod_view),
        .icr_view_i(icr_view), .ta_pb_i(ta_pb), .tb_pb_i(tb_pb),
        .ta_underflow_i(ta_uf), .acc_o(acc), .count_src_o(count_src)
    );

    cia_interval_timer #(.TIMER_SEL(TIMER_A)) u_timer_a (
        .CLK_I(CLK_I), .reset_n(reset_n), .acc_i(acc), .count_src_i(count_src),
        .view_o(ta_view), .pb_o(ta_pb), .underflow_o(ta_uf)
    );

    cia_interval_timer #(.TIMER_SEL(TIMER_B)) u_timer_b (
        .CLK_I(CLK_I), .reset_n(reset_n), .acc_i(acc), .count_src_i(count_src),
        .view_o(tb_view), .pb_o(tb_pb), .underflow_o(tb_uf)
    );

    cia_tod_clock u_tod_clock (
        .CLK_I(CLK_I), .reset_n(reset_n), .acc_i(acc), .tod_i(tod_i),
        .alarm_sel_i(tb_view.cr.alarm_sel), .view_o(tod_view), .alarm_o(tod_alarm)
    );

    cia_irq_ctrl u_irq_ctrl (
        .CLK_I(CLK_I), .reset_n(reset_n), .acc_i(acc), .src_i(irq_src),
        .view_o(icr_view), .irq_n_o(irq_n_o)
    );

endmodule

//--- cia_tb_tasks.svh
// Testbench helpers for the 8520 adapter
// WISHBONE read and write tasks with ACK timeout
// Xorshift generator, error reporting and test counters

`ifndef CIA_TB_TASKS_SVH
`define CIA_TB_TASKS_SVH

localparam int BUS_TIMEOUT = 8;

int          errors = 0;
int          errors_at_start = 0;
int          tests_run = 0;
logic [31:0] rng_state = 32'h88f7_c621;

function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
endfunction

function automatic void report_mismatch(input string name, input logic [31:0] got,
                                        input logic [31:0] exp);
    errors++;
    $display("MISMATCH at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
endfunction

function automatic void report_timeout(input string what);
    errors++;
    $display("TIMEOUT at %0d ns: %s", $time, what);
endfunction

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got == exp) else report_mismatch(name, got, exp);
endtask

// Inputs change 1 ns after the rising edge
task automatic next_cycle();
    @(posedge CLK_I);
    #1;
endtask

task automatic bus_access(input logic we, input reg_addr_e addr, input logic [7:0] wdata,
                          output logic [7:0] rdata);
    int waited;
    rdata = 8'h00;
    wb.cyc = 1'b1;
    wb.stb = 1'b1;
    wb.we = we;
    wb.adr = addr;
    wb.dat = wdata;
    waited = 0;
    do begin
        next_cycle();
        waited++;
    end while (!ack_o && waited < BUS_TIMEOUT);
    if (ack_o) begin
        rdata = dat_o;
        // Hold the request through the ACK cycle, where it commits
        next_cycle();
    end else begin
        report_timeout($sformatf("no ACK for access to %s", addr.name()));
    end
    wb.cyc = 1'b0;
    wb.stb = 1'b0;
    wb.we = 1'b0;
endtask

task automatic bus_write(input reg_addr_e addr, input logic [7:0] data);
    logic [7:0] unused;
    bus_access(1'b1, addr, data, unused);
endtask

task automatic bus_read(input reg_addr_e addr);
    logic [7:0] unused;
    bus_access(1'b0, addr, 8'h00, unused);
endtask

// Read data is compared by the a_rd_data assertion in the ACK cycle
task automatic read_expect(input reg_addr_e addr, input logic [7:0] exp);
    exp_rd = exp;
    rd_name = addr.name();
    chk_rd = 1'b1;
    bus_read(addr);
    chk_rd = 1'b0;
endtask

task automatic finish_test(input string name);
    tests_run++;
    if (errors == errors_at_start) begin
        $display("test %0d %s: ok", tests_run, name);
    end else begin
        $display("test %0d %s: %0d errors", tests_run, name, errors - errors_at_start);
    end
    errors_at_start = errors;
endtask

`endif

//--- cia_tb.sv
`timescale 1ns/1ps
// Testbench for the 8520 adapter top level
// Clock, reset, DUT, checking assertions and the test sequence
// Covers ports, both timers, TOD clock and the interrupt controller

module cia_tb;
    import cia_pkg::*;

    logic        CLK_I;
    logic        reset_n;
    wb_req_t     wb;
    logic        ack_o;
    logic [7:0]  dat_o;
    logic        phi_tick;
    logic [7:0]  pa_pins;
    logic [7:0]  pb_pins;
    logic [7:0]  pa_o;
    logic [7:0]  pb_o;
    logic        flag_n;
    logic        tod_in;
    logic        cnt_in;
    logic        irq_n_o;

    // Check enables and expected values driven by the sequence
    logic        chk_rd = 1'b0;
    logic [7:0]  exp_rd = 8'h00;
    string       rd_name = "";
    logic        chk_port = 1'b0;
    logic [7:0]  exp_pa = 8'h00;
    logic [7:0]  exp_pb = 8'h00;
    logic        chk_pb6 = 1'b0;
    logic        exp_pb6 = 1'b0;
    logic        chk_irq = 1'b0;
    logic        exp_irq_n = 1'b1;

    logic [7:0]  ddra;
    logic [7:0]  pra;
    logic [7:0]  ddrb;
    logic [7:0]  prb;
    logic [23:0] tod_val;
    logic [23:0] alarm_val;
    int          n_ticks;
    int          latch_a;
    int          latch_b;
    int          ta_pulses;
    int          waited;

    `include "cia_tb_tasks.svh"

    cia_top u_cia_top (
        .CLK_I(CLK_I), .reset_n(reset_n), .wb_i(wb), .ack_o(ack_o), .dat_o(dat_o),
        .phi_tick_i(phi_tick), .pa_i(pa_pins), .pb_i(pb_pins), .pa_o(pa_o), .pb_o(pb_o),
        .flag_n_i(flag_n), .tod_i(tod_in), .cnt_i(cnt_in), .irq_n_o(irq_n_o)
    );

    always #50 CLK_I = ~CLK_I;

    a_rd_data: assert property (
        @(posedge CLK_I) disable iff (!reset_n) (ack_o && chk_rd) |-> (dat_o == exp_rd)
    ) else report_mismatch(rd_name, $sampled(dat_o), $sampled(exp_rd));

    a_pa: assert property (@(posedge CLK_I) disable iff (!reset_n) chk_port |-> (pa_o == exp_pa))
        else report_mismatch("pa_o", $sampled(pa_o), $sampled(exp_pa));

    a_pb: assert property (@(posedge CLK_I) disable iff (!reset_n) chk_port |-> (pb_o == exp_pb))
        else report_mismatch("pb_o", $sampled(pb_o), $sampled(exp_pb));

    a_pb6: assert property (
        @(posedge CLK_I) disable iff (!reset_n) chk_pb6 |-> (pb_o[6] == exp_pb6)
    ) else report_mismatch("pb_o[6]", $sampled(pb_o[6]), $sampled(exp_pb6));

    a_irq_n: assert property (
        @(posedge CLK_I) disable iff (!reset_n) chk_irq |-> (irq_n_o == exp_irq_n)
    ) else report_mismatch("irq_n_o", $sampled(irq_n_o), $sampled(exp_irq_n));

    task automatic pulse_tod();
        tod_in = 1'b1;
        next_cycle();
        tod_in = 1'b0;
        next_cycle();
    endtask

    task automatic pulse_flag();
        flag_n = 1'b0;
        next_cycle();
        flag_n = 1'b1;
        next_cycle();
    endtask

    initial begin
        CLK_I = 1'b0;
        reset_n = 1'b0;
        wb = '0;
        phi_tick = 1'b0;
        pa_pins = 8'h00;
        pb_pins = 8'h00;
        flag_n = 1'b1;
        tod_in = 1'b0;
        cnt_in = 1'b0;
        repeat (5) @(posedge CLK_I);
        #1;
        reset_n = 1'b1;
        next_cycle();

        // Ports with random direction, register and pin values
        for (int i = 0; i < 4; i++) begin
            chk_port = 1'b0;
            ddra = 8'(next_random());
            pra = 8'(next_random());
            ddrb = 8'(next_random());
            prb = 8'(next_random());
            bus_write(DDRA, ddra);
            bus_write(PRA, pra);
            bus_write(DDRB, ddrb);
            bus_write(PRB, prb);
            pa_pins = 8'(next_random());
            pb_pins = 8'(next_random());
            exp_pa = (ddra & pra) | (~ddra & pa_pins);
            exp_pb = (ddrb & prb) | (~ddrb & pb_pins);
            chk_port = 1'b1;
            next_cycle();
            next_cycle();
            read_expect(PRA, exp_pa);
            read_expect(PRB, exp_pb);
        end
        chk_port = 1'b0;
        finish_test("ports");

        // Timer A one-shot in pulse mode on PB6
        n_ticks = 3 + int'(next_random() % 8);
        bus_write(CRA, 8'h0a);
        bus_write(TALO, 8'(n_ticks));
        bus_write(TAHI, 8'h00);
        exp_pb6 = 1'b0;
        chk_pb6 = 1'b1;
        phi_tick = 1'b1;
        repeat (n_ticks) next_cycle();
        phi_tick = 1'b0;
        // Underflow on the last tick and PB6 one cycle later
        next_cycle();
        exp_pb6 = 1'b1;
        next_cycle();
        exp_pb6 = 1'b0;
        next_cycle();
        next_cycle();
        chk_pb6 = 1'b0;
        read_expect(ICR, 8'h01);
        read_expect(CRA, 8'h0a);
        bus_write(ICR, 8'h81);
        bus_write(TAHI, 8'h00);
        phi_tick = 1'b1;
        waited = 0;
        while (irq_n_o !== 1'b0 && waited < n_ticks + 4) begin
            next_cycle();
            waited++;
        end
        phi_tick = 1'b0;
        if (irq_n_o !== 1'b0) report_timeout("irq_n did not fall on masked timer A underflow");
        exp_irq_n = 1'b0;
        chk_irq = 1'b1;
        read_expect(ICR, 8'h81);
        exp_irq_n = 1'b1;
        next_cycle();
        next_cycle();
        chk_irq = 1'b0;
        bus_write(ICR, 8'h01);
        finish_test("timer A one-shot");

        // Timer B counts timer A underflows with both PB pins in pulse mode
        latch_a = 4 + int'(next_random() % 8);
        latch_b = 2 + int'(next_random() % 4);
        bus_write(CRA, 8'h00);
        bus_write(TALO, 8'(latch_a));
        bus_write(TAHI, 8'h00);
        bus_write(TBLO, 8'(latch_b));
        bus_write(TBHI, 8'h00);
        bus_write(CRB, 8'h43);
        phi_tick = 1'b1;
        bus_write(CRA, 8'h03);
        ta_pulses = 0;
        waited = 0;
        while (pb_o[7] !== 1'b1 && waited < 400) begin
            if (pb_o[6] === 1'b1) ta_pulses++;
            next_cycle();
            waited++;
        end
        phi_tick = 1'b0;
        if (pb_o[7] !== 1'b1) report_timeout("timer B never underflowed in cascade mode");
        check_value("timer A underflows before timer B", ta_pulses, latch_b);
        read_expect(TBLO, 8'(latch_b));
        read_expect(ICR, 8'h03);
        bus_write(CRA, 8'h00);
        bus_write(CRB, 8'h00);
        finish_test("timer B cascade");

        // TOD set, count, read latch and alarm
        tod_val = 24'(next_random()) & 24'h7fffff;
        bus_write(TOD_HI, tod_val[23:16]);
        bus_write(TOD_MID, tod_val[15:8]);
        bus_write(TOD_LO, tod_val[7:0]);
        n_ticks = 3 + int'(next_random() % 6);
        repeat (n_ticks) pulse_tod();
        tod_val = tod_val + 24'(n_ticks);
        read_expect(TOD_HI, tod_val[23:16]);
        read_expect(TOD_MID, tod_val[15:8]);
        read_expect(TOD_LO, tod_val[7:0]);
        read_expect(TOD_HI, tod_val[23:16]);
        repeat (3) pulse_tod();
        read_expect(TOD_LO, tod_val[7:0]);
        tod_val = tod_val + 24'd3;
        read_expect(TOD_LO, tod_val[7:0]);
        alarm_val = tod_val + 24'd2;
        bus_write(CRB, 8'h80);
        bus_write(TOD_HI, alarm_val[23:16]);
        bus_write(TOD_MID, alarm_val[15:8]);
        bus_write(TOD_LO, alarm_val[7:0]);
        bus_write(CRB, 8'h00);
        // Partial alarm writes may match for a cycle
        bus_read(ICR);
        pulse_tod();
        read_expect(ICR, 8'h00);
        pulse_tod();
        read_expect(ICR, 8'h04);
        pulse_tod();
        read_expect(ICR, 8'h04);
        finish_test("time of day");

        // FLAG input with mask clear, set and clear again
        exp_irq_n = 1'b1;
        chk_irq = 1'b1;
        pulse_flag();
        next_cycle();
        read_expect(ICR, 8'h10);
        chk_irq = 1'b0;
        bus_write(ICR, 8'h90);
        pulse_flag();
        waited = 0;
        while (irq_n_o !== 1'b0 && waited < 4) begin
            next_cycle();
            waited++;
        end
        if (irq_n_o !== 1'b0) report_timeout("irq_n did not fall on masked FLAG event");
        exp_irq_n = 1'b0;
        chk_irq = 1'b1;
        read_expect(ICR, 8'h90);
        exp_irq_n = 1'b1;
        next_cycle();
        bus_write(ICR, 8'h10);
        pulse_flag();
        next_cycle();
        read_expect(ICR, 8'h10);
        chk_irq = 1'b0;
        finish_test("interrupt mask and FLAG");

        $display("tests run: %0d, errors: %0d", tests_run, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- cia.f
+incdir+.
cia_pkg.sv
cia_ctrl_regs.sv
cia_interval_timer.sv
cia_tod_clock.sv
cia_irq_ctrl.sv
cia_top.sv
cia_tb.sv
